// File: common/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// accumulator, 16-bit product plus 8 bits of headroom
`define CONV_ACC_WIDTH   24
`define CONV_LANES       2   // output channels per operand word
`define CONV_COUNT_WIDTH 16  // term and pixel counts
`define CONV_RANK_BITS   5   // used low bits of scale rank

`endif

// File: common/conv_cfg_pkg.sv
`include "conv_params.svh"

package conv_cfg_pkg;

    //////////////////////////////
    // operating mode

    typedef enum logic {
        MODE_88 = 1'b0, // 8-bit weight, lane 0 only
        MODE_18 = 1'b1  // two 4-bit weights, both lanes
    } conv_mode_e;

    //////////////////////////////
    // requantization, one set per lane

    typedef struct packed {
        logic signed [7:0] bias;
        logic [15:0]       scale_tail; // unsigned multiplier
        logic [7:0]        scale_rank; // right shift, low bits only
    } conv_quant_t;

    //////////////////////////////
    // tile configuration

    typedef struct packed {
        conv_mode_e                   mode;
        logic [`CONV_COUNT_WIDTH-1:0] terms;  // nif * k * k per output pixel
        logic [`CONV_COUNT_WIDTH-1:0] pixels; // output pixels in the tile
        conv_quant_t [`CONV_LANES-1:0] quant; // index = lane
    } conv_cfg_t;

endpackage

// File: common/conv_data_pkg.sv
`include "conv_params.svh"

package conv_data_pkg;

    //////////////////////////////
    // weight word

    // two nibble weights of the 1x8 style mode
    typedef struct packed {
        logic signed [3:0] hi; // lane 1
        logic signed [3:0] lo; // lane 0
    } conv_w18_t;

    // one byte, read either way depending on mode
    typedef union packed {
        logic signed [7:0] w88;
        conv_w18_t         w18;
    } conv_weight_u;

    //////////////////////////////
    // operand stream

    typedef struct packed {
        logic [7:0]   pixel; // unsigned activation
        conv_weight_u weight;
    } conv_operand_t;

    //////////////////////////////
    // sums and results

    typedef logic signed [`CONV_ACC_WIDTH-1:0] conv_sum_t;
    typedef conv_sum_t [`CONV_LANES-1:0] conv_acc_t; // index = lane

    typedef struct packed {
        logic signed [7:0] lane1;
        logic signed [7:0] lane0;
    } conv_result_t;

endpackage

// File: source/conv_sequencer.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module conv_sequencer import conv_cfg_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      en,         // start pulse
    input  conv_cfg_t cfg,
    input  logic      last_term,
    input  logic      last_pixel,
    input  logic      out_valid,
    output conv_cfg_t cfg_q,
    output logic      run,
    output logic      busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,   // operands streaming
        S_DRAIN  // waiting for the requant pipeline
    } seq_state_e;

    seq_state_e                   state;
    logic [`CONV_COUNT_WIDTH-1:0] pending; // results still to come
    logic                         accept;

    assign accept = (state == S_IDLE) && en; // en while busy is dropped
    assign busy   = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            run     <= 1'b0;
            pending <= '0;
            cfg_q   <= '0;
        end else begin
            if (accept) begin
                cfg_q   <= cfg;
                pending <= cfg.pixels;
            end else if (out_valid) begin
                pending <= pending - 1'b1;
            end

            case (state)
                S_IDLE: if (accept) begin
                    state <= S_RUN;
                    run   <= 1'b1;
                end
                S_RUN: if (last_term && last_pixel) begin
                    state <= S_DRAIN; // final operand consumed this edge
                    run   <= 1'b0;
                end
                S_DRAIN: if (out_valid && pending == 1) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // empty tiles would never finish
    a_cfg_nonzero: assert property (@(posedge clk) disable iff (reset)
        accept |-> (cfg.terms != 0 && cfg.pixels != 0));

    a_run_in_busy: assert property (@(posedge clk) disable iff (reset)
        $rose(run) |-> busy);

endmodule

// File: source/conv_step_counter.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module conv_step_counter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  logic [`CONV_COUNT_WIDTH-1:0] terms,
    input  logic [`CONV_COUNT_WIDTH-1:0] pixels,
    output logic                         first_term,
    output logic                         last_term,
    output logic                         last_pixel
);

    logic [`CONV_COUNT_WIDTH-1:0] term_idx;
    logic [`CONV_COUNT_WIDTH-1:0] pix_idx;

    //////////////////////////////
    // index stepping

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            term_idx <= '0; // next tile starts at term 0 of pixel 0
            pix_idx  <= '0;
        end else if (last_term) begin
            term_idx <= '0;
            pix_idx  <= last_pixel ? '0 : pix_idx + 1'b1;
        end else begin
            term_idx <= term_idx + 1'b1;
        end
    end

    //////////////////////////////
    // flags from current indices

    assign first_term = (term_idx == '0);
    assign last_term  = (term_idx == terms - 1'b1);
    assign last_pixel = (pix_idx == pixels - 1'b1);

    a_term_range: assert property (@(posedge clk) disable iff (reset)
        run |-> term_idx < terms);

endmodule

// File: conv_mac/conv_mac_lanes.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module conv_mac_lanes import conv_cfg_pkg::*, conv_data_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          run,
    input  conv_mode_e    mode,
    input  logic          first_term,
    input  logic          last_term,
    input  conv_operand_t operand,
    output logic          acc_done,
    output conv_acc_t     acc
);

    logic signed [7:0]                 lane_w   [`CONV_LANES];
    logic signed [8:0]                 pix_s;
    logic signed [`CONV_ACC_WIDTH-1:0] prod     [`CONV_LANES];
    logic signed [`CONV_ACC_WIDTH-1:0] sum_next [`CONV_LANES];
    conv_acc_t                         acc_run;   // running sums

    //////////////////////////////
    // weight decode and multiply

    always_comb begin
        if (mode == MODE_18) begin
            lane_w[0] = operand.weight.w18.lo; // nibbles sign-extend
            lane_w[1] = operand.weight.w18.hi;
        end else begin
            lane_w[0] = operand.weight.w88;
            lane_w[1] = '0; // lane 1 idle in 8x8
        end
        pix_s = {1'b0, operand.pixel};
        for (int l = 0; l < `CONV_LANES; l++) begin
            prod[l]     = pix_s * lane_w[l];
            sum_next[l] = first_term ? prod[l] : acc_run[l] + prod[l]; // wraps
        end
    end

    //////////////////////////////
    // accumulate, hand off on last term

    always_ff @(posedge clk) begin
        if (run) begin
            for (int l = 0; l < `CONV_LANES; l++) begin
                acc_run[l] <= sum_next[l];
                if (last_term) acc[l] <= sum_next[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) acc_done <= 1'b0;
        else       acc_done <= run && last_term; // one pulse per pixel
    end

endmodule

// File: conv_requant/conv_requant.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module conv_requant import conv_cfg_pkg::*, conv_data_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          acc_done,
    input  conv_acc_t                     acc,
    input  conv_quant_t [`CONV_LANES-1:0] quant,
    input  conv_mode_e                    mode,
    output logic                          out_valid,
    output conv_result_t                  result
);

    logic signed [39:0] prod_c [`CONV_LANES];
    logic signed [39:0] prod_q [`CONV_LANES];
    logic signed [7:0]  sat_c  [`CONV_LANES];
    logic               valid_s1;

    //////////////////////////////
    // stage 1: bias and scale tail

    always_comb begin : stage1
        logic signed [`CONV_ACC_WIDTH-1:0] sum_l;
        logic signed [7:0]                 bias_l;
        logic signed [`CONV_ACC_WIDTH-1:0] biased;
        logic signed [16:0]                tail_s;
        for (int l = 0; l < `CONV_LANES; l++) begin
            sum_l     = acc[l];
            bias_l    = quant[l].bias;
            biased    = sum_l + bias_l; // 24-bit wrap
            tail_s    = {1'b0, quant[l].scale_tail};
            prod_c[l] = biased * tail_s;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < `CONV_LANES; l++) prod_q[l] <= prod_c[l];
    end

    //////////////////////////////
    // stage 2: rank shift and clamp

    always_comb begin : stage2
        logic signed [39:0] shifted;
        for (int l = 0; l < `CONV_LANES; l++) begin
            shifted = prod_q[l] >>> quant[l].scale_rank[`CONV_RANK_BITS-1:0];
            if (shifted > 40'sd127)       sat_c[l] = 8'sd127;
            else if (shifted < -40'sd128) sat_c[l] = 8'sh80;
            else                          sat_c[l] = shifted[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1  <= 1'b0;
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            valid_s1  <= acc_done;
            out_valid <= valid_s1;
            if (valid_s1) begin
                result.lane0 <= sat_c[0];
                result.lane1 <= (mode == MODE_18) ? sat_c[1] : '0; // single channel in 8x8
            end
        end
    end

    a_latency: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(acc_done, 2));

endmodule

// File: source/conv_datapath.sv
`timescale 1ns/1ns

module conv_datapath import conv_cfg_pkg::*, conv_data_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          en,
    input  conv_cfg_t     cfg,
    input  conv_operand_t operand,
    output logic          busy,
    output logic          out_valid,
    output conv_result_t  result
);

    conv_cfg_t cfg_q;
    logic      run;
    logic      first_term;
    logic      last_term;
    logic      last_pixel;
    logic      acc_done;
    conv_acc_t acc;

    //////////////////////////////
    // control

    conv_sequencer seq_i (
        .clk        (clk),
        .reset      (reset),
        .en         (en),
        .cfg        (cfg),
        .last_term  (last_term),
        .last_pixel (last_pixel),
        .out_valid  (out_valid),
        .cfg_q      (cfg_q),
        .run        (run),
        .busy       (busy)
    );

    conv_step_counter cnt_i (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .terms      (cfg_q.terms),
        .pixels     (cfg_q.pixels),
        .first_term (first_term),
        .last_term  (last_term),
        .last_pixel (last_pixel)
    );

    //////////////////////////////
    // arithmetic

    conv_mac_lanes mac_i (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .mode       (cfg_q.mode),
        .first_term (first_term),
        .last_term  (last_term),
        .operand    (operand),
        .acc_done   (acc_done),
        .acc        (acc)
    );

    conv_requant rq_i (
        .clk        (clk),
        .reset      (reset),
        .acc_done   (acc_done),
        .acc        (acc),
        .quant      (cfg_q.quant),
        .mode       (cfg_q.mode),
        .out_valid  (out_valid),
        .result     (result)
    );

endmodule

// File: bench/conv_datapath_tb.sv
`timescale 1ns/1ns

module conv_datapath_tb import conv_cfg_pkg::*, conv_data_pkg::*; ();

    localparam longint PERIOD  = 20;
    localparam int     N_TILES = 7;
    localparam int     MAX_OPS = 64;
    localparam int     MAX_PIX = 8;

    logic          clk;
    logic          reset;
    logic          en;
    conv_cfg_t     cfg;
    conv_operand_t operand;
    logic          busy;
    logic          out_valid;
    conv_result_t  result;

    conv_operand_t ops [MAX_OPS];              // operands of the tile in flight
    conv_result_t  exp_tab [N_TILES][MAX_PIX]; // model results per tile
    conv_result_t  exp_res_q [$];
    longint        exp_time_q [$];             // negedge where each result shows
    logic [31:0]   rng;

    conv_datapath dut_i (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .cfg       (cfg),
        .operand   (operand),
        .busy      (busy),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // helpers and reference model

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // two's complement wrap of a 24-bit accumulator
    function automatic longint wrap24(input longint v);
        longint w;
        w = v & 64'sh00FF_FFFF;
        if (w >= 64'sh0080_0000) w = w - 64'sh0100_0000;
        return w;
    endfunction

    function automatic longint requant_model(input longint sum, input conv_quant_t q);
        longint v;
        v = wrap24(sum + longint'($signed(q.bias))) * longint'(q.scale_tail);
        v = v >>> q.scale_rank[4:0]; // only low 5 rank bits count
        if (v > 64'sd127) v = 64'sd127;
        else if (v < -64'sd128) v = -64'sd128;
        return v;
    endfunction

    function automatic conv_cfg_t tile_row(input conv_mode_e m, input int terms, input int pixels,
                                           input int b0, input int t0, input int r0,
                                           input int b1, input int t1, input int r1);
        conv_cfg_t c;
        c.mode     = m;
        c.terms    = 16'(terms);
        c.pixels   = 16'(pixels);
        c.quant[0] = {8'(b0), 16'(t0), 8'(r0)};
        c.quant[1] = {8'(b1), 16'(t1), 8'(r1)};
        return c;
    endfunction

    // mode, terms, pixels, lane 0 bias tail rank, lane 1 bias tail rank
    function automatic conv_cfg_t tile_entry(input int i);
        conv_cfg_t c;
        case (i)
            0:       c = tile_row(MODE_88,  9, 4,    5,     1,  9,    9,   100, 0);
            1:       c = tile_row(MODE_18, 16, 3,   -3,     3,  7,   10,     5, 8);
            2:       c = tile_row(MODE_88,  1, 6,    0,     1,  8,    0,     0, 0);
            3:       c = tile_row(MODE_18,  1, 5,    2,     1,  4,   -7,     3, 6);
            4:       c = tile_row(MODE_88,  4, 3,    0, 65535,  0,    0,     0, 0); // clamps
            5:       c = tile_row(MODE_18,  3, 2, -100, 60000,  1,  100, 65535, 2); // clamps
            6:       c = tile_row(MODE_88, 25, 2, -128,     7, 44,    0,     0, 0);
            default: c = '0;
        endcase
        return c;
    endfunction

    task automatic model_tile(input int i, input conv_cfg_t c);
        longint       sum0;
        longint       sum1;
        longint       pix;
        logic [7:0]   wb;
        conv_result_t r;
        for (int p = 0; p < int'(c.pixels); p++) begin
            sum0 = 0;
            sum1 = 0;
            for (int t = 0; t < int'(c.terms); t++) begin
                pix = longint'(ops[p * int'(c.terms) + t].pixel);
                wb  = ops[p * int'(c.terms) + t][7:0];
                if (c.mode == MODE_18) begin
                    sum0 = wrap24(sum0 + pix * longint'($signed(wb[3:0]))); // low nibble
                    sum1 = wrap24(sum1 + pix * longint'($signed(wb[7:4])));
                end else begin
                    sum0 = wrap24(sum0 + pix * longint'($signed(wb)));
                end
            end
            r.lane0 = 8'(requant_model(sum0, c.quant[0]));
            r.lane1 = (c.mode == MODE_18) ? 8'(requant_model(sum1, c.quant[1])) : 8'sd0;
            exp_tab[i][p] = r;
        end
    endtask

    task automatic check_value(input string what, input longint got, input longint expected);
        if (got != expected) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    //////////////////////////////
    // result monitor and watchdog

    always @(negedge clk) begin : monitor
        conv_result_t exp_r;
        longint       exp_t;
        if (!reset && out_valid) begin
            if (exp_res_q.size() == 0) begin
                $display("A result appeared at %0t ns while none was pending", $time);
                $display("Result: FAILED");
                $fatal(1, "unexpected result");
            end else begin
                exp_r = exp_res_q.pop_front();
                exp_t = exp_time_q.pop_front();
                check_value("result time", longint'($time), exp_t);
                check_value("lane 0", longint'(result.lane0), longint'(exp_r.lane0));
                check_value("lane 1", longint'(result.lane1), longint'(exp_r.lane1));
            end
        end
    end

    initial begin : watchdog
        longint    cycles;
        conv_cfg_t c;
        cycles = 16;
        for (int i = 0; i < N_TILES; i++) begin
            c      = tile_entry(i);
            cycles = cycles + longint'(c.terms) * longint'(c.pixels) + 10;
        end
        #(cycles * PERIOD);
        $display("Timeout: the tiles did not complete within %0d cycles", cycles);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    //////////////////////////////
    // stimulus

    initial begin
        conv_cfg_t cur;
        conv_cfg_t stray;
        int        n;
        longint    t_en;
        longint    t_exp;
        reset   = 1'b1;
        en      = 1'b0;
        cfg     = '0;
        operand = '0;
        rng     = 32'd52177;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        repeat (4) begin // idle until the first start
            @(negedge clk);
            check_value("busy before start", longint'(busy), 0);
            check_value("out_valid before start", longint'(out_valid), 0);
        end
        for (int i = 0; i < N_TILES; i++) begin
            cur = tile_entry(i);
            n   = int'(cur.terms) * int'(cur.pixels);
            for (int k = 0; k < n; k++) begin
                rng    = next_random(rng);
                ops[k] = rng[15:0];
            end
            model_tile(i, cur);
            stray        = cur;
            stray.terms  = cur.terms + 16'd3; // must not be picked up mid-tile
            stray.pixels = 16'd7;
            @(posedge clk);
            #2;
            cfg = cur;
            en  = 1'b1;
            @(posedge clk);
            t_en = longint'($time);
            for (int p = 0; p < int'(cur.pixels); p++) begin
                t_exp = t_en + PERIOD * longint'((p + 1) * int'(cur.terms) + 2) + PERIOD / 2;
                exp_res_q.push_back(exp_tab[i][p]);
                exp_time_q.push_back(t_exp);
            end
            #2;
            for (int k = 0; k < n; k++) begin
                operand = ops[k];
                en      = (n >= 4 && k == n / 2); // stray start while busy
                cfg     = en ? stray : cur;
                if (k == 0) check_value("busy during tile", longint'(busy), 1);
                @(posedge clk);
                #2;
            end
            en      = 1'b0;
            cfg     = cur;
            operand = '0;
            while (busy) @(negedge clk);
            t_exp = t_en + PERIOD * longint'(n + 3) + PERIOD / 2;
            check_value("busy fall time", longint'($time), t_exp);
            check_value("results still pending", longint'(exp_res_q.size()), 0);
        end
        repeat (3) @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: all.f
+incdir+common
common/conv_cfg_pkg.sv
common/conv_data_pkg.sv
source/conv_sequencer.sv
source/conv_step_counter.sv
conv_mac/conv_mac_lanes.sv
conv_requant/conv_requant.sv
source/conv_datapath.sv
bench/conv_datapath_tb.sv

// File: Makefile
TOP := conv_datapath_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
